// ==== src/coeff_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "prng_params.svh"

module coeff_store (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         load,
    input  wire prng_pkg::fix_t         a00,
    input  wire prng_pkg::fix_t         a01,
    input  wire prng_pkg::fix_t         a02,
    input  wire prng_pkg::fix_t         a10,
    input  wire prng_pkg::fix_t         a11,
    input  wire prng_pkg::fix_t         a12,
    input  wire prng_pkg::fix_t         a20,
    input  wire prng_pkg::fix_t         a21,
    input  wire prng_pkg::fix_t         a22,
    input  wire prng_pkg::fix_t         sigma,
    input  wire prng_pkg::prng_state_t  phase,
    input  wire prng_pkg::lane_t        row,
    input  wire prng_pkg::lane_t        col,
    output prng_pkg::fix_t              coeff
);
    import prng_pkg::*;

    localparam int N_COEF = `PRNG_LANES * `PRNG_LANES;

    fix_t a_in [N_COEF];
    fix_t a_q [N_COEF];
    fix_t sigma_q;

    // row-major flattening of the matrix
    assign a_in = '{a00, a01, a02, a10, a11, a12, a20, a21, a22};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N_COEF; i++) begin
                a_q[i] <= '0;
            end
            sigma_q <= '0;
        end else if (load) begin
            for (int i = 0; i < N_COEF; i++) begin
                a_q[i] <= a_in[i];
            end
            sigma_q <= sigma;
        end
    end

    // multiplicand for this step
    always_comb begin
        case (phase)
            SCALE:   coeff = sigma_q;
            AFFINE:  coeff = a_q[int'(row) * `PRNG_LANES + int'(col)];
            default: coeff = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/mac_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "prng_params.svh"

module mac_unit (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire prng_pkg::prng_state_t  phase,
    input  wire prng_pkg::lane_t        col,
    input  wire prng_pkg::fix_t         coeff,
    input  wire prng_pkg::fix_t         operand,
    input  wire prng_pkg::fix_t         noise,
    output prng_pkg::fix_t              frac_out,
    output prng_pkg::fix_t              acc_out
);
    import prng_pkg::*;

    localparam int WORD_BITS = $bits(fix_t);

    prod_t full_prod;
    fix_t  scaled;
    fix_t  saw;
    fix_t  acc_base;

    // ======================================================================
    // q16.16 multiply
    // ======================================================================

    // sign-extended 64 bit product
    assign full_prod = prod_t'(coeff) * prod_t'(operand);

    // drop the extra fraction bits, keep low word
    assign scaled = fix_t'(full_prod >>> `PRNG_FRAC_BITS);

    // sawtooth, fraction only, always in [0,1)
    assign saw = {{(WORD_BITS - `PRNG_FRAC_BITS){1'b0}}, scaled[`PRNG_FRAC_BITS-1:0]};

    // ======================================================================
    // row accumulator
    // ======================================================================

    // column 0 starts a new row from its noise term
    assign acc_base = (col == '0) ? noise : acc_out;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            frac_out <= '0;
            acc_out  <= '0;
        end else begin
            if (phase == SCALE) begin
                frac_out <= saw;
            end
            // sums wrap mod 2^32
            if (phase == AFFINE) begin
                acc_out <= acc_base + scaled;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/prng_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module prng_control (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   start,
    input  wire                   last_step,
    output prng_pkg::prng_state_t phase,
    output logic                  load,
    output logic                  publish
);
    import prng_pkg::*;

    prng_state_t state;
    prng_state_t state_next;

    // ======================================================================
    // next state
    // ======================================================================

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                state_next = IDLE;
            end
            SCALE: begin
                if (last_step) begin
                    state_next = AFFINE;
                end
            end
            AFFINE: begin
                if (last_step) begin
                    state_next = PUBLISH;
                end
            end
            PUBLISH: begin
                // loop back for the next iterate
                if (last_step) begin
                    state_next = SCALE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
        // start wins from any state
        if (start) begin
            state_next = SCALE;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ======================================================================
    // outputs
    // ======================================================================

    // start cycle seen as idle downstream
    // so the step counter rewinds and the mac does nothing
    assign phase = start ? IDLE : state;

    // seeds and coefficients captured on the start edge itself
    assign load = start;

    // a restart aborts the pending publish
    assign publish = (state == PUBLISH) && !start;

endmodule

`default_nettype wire

// ==== src/prng_params.svh ====
`ifndef PRNG_PARAMS_SVH
`define PRNG_PARAMS_SVH

// ======================================================================
// fixed point format
// ======================================================================

// q16.16, bits below the binary point
`define PRNG_FRAC_BITS 16

// ======================================================================
// generator shape
// ======================================================================

// state dimension, also the matrix order
`define PRNG_LANES 3

// scale phase, one multiply per lane
`define PRNG_SCALE_STEPS (`PRNG_LANES)
// affine phase, one multiply per matrix entry
`define PRNG_AFFINE_STEPS (`PRNG_LANES * `PRNG_LANES)
// publish phase
`define PRNG_PUBLISH_STEPS 1

// start of an iteration to its valid pulse
`define PRNG_ITER_CYCLES (`PRNG_SCALE_STEPS + `PRNG_AFFINE_STEPS + `PRNG_PUBLISH_STEPS)

`endif

// ==== src/prng_pkg.sv ====
`default_nettype none

`include "prng_params.svh"

package prng_pkg;

    // ======================================================================
    // datapath types
    // ======================================================================

    // one q16.16 value, two's complement
    typedef logic signed [31:0] fix_t;

    // full product before rescaling
    typedef logic signed [63:0] prod_t;

    // row or column of the state / matrix
    typedef logic [$clog2(`PRNG_LANES)-1:0] lane_t;

    // ======================================================================
    // control
    // ======================================================================

    // iteration sequence, idle only before the first start
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        SCALE   = 2'd1,
        AFFINE  = 2'd2,
        PUBLISH = 2'd3
    } prng_state_t;

endpackage

`default_nettype wire

// ==== src/prng_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module prng_top (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 start,
    input  wire prng_pkg::fix_t seed0,
    input  wire prng_pkg::fix_t seed1,
    input  wire prng_pkg::fix_t seed2,
    input  wire prng_pkg::fix_t a00,
    input  wire prng_pkg::fix_t a01,
    input  wire prng_pkg::fix_t a02,
    input  wire prng_pkg::fix_t a10,
    input  wire prng_pkg::fix_t a11,
    input  wire prng_pkg::fix_t a12,
    input  wire prng_pkg::fix_t a20,
    input  wire prng_pkg::fix_t a21,
    input  wire prng_pkg::fix_t a22,
    input  wire prng_pkg::fix_t sigma,
    output logic                valid,
    output prng_pkg::fix_t      rand0,
    output prng_pkg::fix_t      rand1,
    output prng_pkg::fix_t      rand2
);
    import prng_pkg::*;

    // sequencing
    prng_state_t phase;
    logic        load;
    logic        publish;
    lane_t       row;
    lane_t       col;
    logic        last_step;

    // datapath
    fix_t coeff;
    fix_t operand;
    fix_t noise;
    fix_t frac_out;
    fix_t acc_out;

    // ======================================================================
    // control
    // ======================================================================

    prng_control u_control (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .last_step (last_step),
        .phase     (phase),
        .load      (load),
        .publish   (publish)
    );

    step_counter u_step_counter (
        .clk       (clk),
        .reset_n   (reset_n),
        .phase     (phase),
        .row       (row),
        .col       (col),
        .last_step (last_step)
    );

    // ======================================================================
    // datapath
    // ======================================================================

    coeff_store u_coeff_store (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (load),
        .a00     (a00),
        .a01     (a01),
        .a02     (a02),
        .a10     (a10),
        .a11     (a11),
        .a12     (a12),
        .a20     (a20),
        .a21     (a21),
        .a22     (a22),
        .sigma   (sigma),
        .phase   (phase),
        .row     (row),
        .col     (col),
        .coeff   (coeff)
    );

    state_store u_state_store (
        .clk      (clk),
        .reset_n  (reset_n),
        .load     (load),
        .publish  (publish),
        .seed0    (seed0),
        .seed1    (seed1),
        .seed2    (seed2),
        .phase    (phase),
        .row      (row),
        .col      (col),
        .frac_out (frac_out),
        .acc_out  (acc_out),
        .operand  (operand),
        .noise    (noise),
        .rand0    (rand0),
        .rand1    (rand1),
        .rand2    (rand2),
        .valid    (valid)
    );

    // single shared multiplier for both phases
    mac_unit u_mac_unit (
        .clk      (clk),
        .reset_n  (reset_n),
        .phase    (phase),
        .col      (col),
        .coeff    (coeff),
        .operand  (operand),
        .noise    (noise),
        .frac_out (frac_out),
        .acc_out  (acc_out)
    );

endmodule

`default_nettype wire

// ==== src/state_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "prng_params.svh"

module state_store (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         load,
    input  wire                         publish,
    input  wire prng_pkg::fix_t         seed0,
    input  wire prng_pkg::fix_t         seed1,
    input  wire prng_pkg::fix_t         seed2,
    input  wire prng_pkg::prng_state_t  phase,
    input  wire prng_pkg::lane_t        row,
    input  wire prng_pkg::lane_t        col,
    input  wire prng_pkg::fix_t         frac_out,
    input  wire prng_pkg::fix_t         acc_out,
    output prng_pkg::fix_t              operand,
    output prng_pkg::fix_t              noise,
    output prng_pkg::fix_t              rand0,
    output prng_pkg::fix_t              rand1,
    output prng_pkg::fix_t              rand2,
    output logic                        valid
);
    import prng_pkg::*;

    localparam lane_t LAST_LANE = lane_t'(`PRNG_LANES - 1);

    fix_t        x_q [`PRNG_LANES];
    fix_t        u_q [`PRNG_LANES];
    fix_t        nxt_q [`PRNG_LANES];
    fix_t        nxt_view [`PRNG_LANES];
    fix_t        seed_in [`PRNG_LANES];
    prng_state_t phase_d;
    lane_t       row_d;
    lane_t       col_d;
    logic        u_wr;
    logic        nxt_wr;

    assign seed_in = '{seed0, seed1, seed2};

    // ======================================================================
    // write strobes
    // ======================================================================

    // mac result lags its step by one cycle
    // so writes follow the step index of the cycle before
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase_d <= IDLE;
            row_d   <= '0;
            col_d   <= '0;
        end else begin
            phase_d <= phase;
            row_d   <= row;
            col_d   <= col;
        end
    end

    assign u_wr   = (phase_d == SCALE);
    // row sum complete after its last column
    assign nxt_wr = (phase_d == AFFINE) && (col_d == LAST_LANE);

    // last row lands during publish, bypass it
    always_comb begin
        for (int i = 0; i < `PRNG_LANES; i++) begin
            nxt_view[i] = (nxt_wr && (row_d == lane_t'(i))) ? acc_out : nxt_q[i];
        end
    end

    // ======================================================================
    // state, noise and next-state rows
    // ======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `PRNG_LANES; i++) begin
                x_q[i]   <= '0;
                u_q[i]   <= '0;
                nxt_q[i] <= '0;
            end
        end else if (load) begin
            for (int i = 0; i < `PRNG_LANES; i++) begin
                x_q[i] <= seed_in[i];
            end
        end else begin
            if (u_wr) begin
                u_q[row_d] <= frac_out;
            end
            if (nxt_wr) begin
                nxt_q[row_d] <= acc_out;
            end
            // feedback, new state for the next iteration
            if (publish) begin
                for (int i = 0; i < `PRNG_LANES; i++) begin
                    x_q[i] <= nxt_view[i];
                end
            end
        end
    end

    // x at row for scale, x at col for the matrix product
    assign operand = (phase == AFFINE) ? x_q[col] : x_q[row];
    assign noise   = u_q[row];

    // ======================================================================
    // outputs
    // ======================================================================

    // published value is the state itself
    assign rand0 = x_q[0];
    assign rand1 = x_q[1];
    assign rand2 = x_q[2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid <= 1'b0;
        end else begin
            valid <= publish && !load;
        end
    end

endmodule

`default_nettype wire

// ==== src/step_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "prng_params.svh"

module step_counter (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire prng_pkg::prng_state_t  phase,
    output prng_pkg::lane_t             row,
    output prng_pkg::lane_t             col,
    output logic                        last_step
);
    import prng_pkg::*;

    localparam lane_t LAST_LANE = lane_t'(`PRNG_LANES - 1);

    // final index of each phase
    always_comb begin
        case (phase)
            SCALE:   last_step = (row == LAST_LANE);
            AFFINE:  last_step = (row == LAST_LANE) && (col == LAST_LANE);
            PUBLISH: last_step = 1'b1;
            default: last_step = 1'b0;
        endcase
    end

    // last step is also the phase change, so clear there
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            row <= '0;
            col <= '0;
        end else if ((phase == IDLE) || last_step) begin
            row <= '0;
            col <= '0;
        end else if ((phase == AFFINE) && (col != LAST_LANE)) begin
            // row-major, column first
            col <= col + 1'b1;
        end else begin
            // scale keeps col at zero
            col <= '0;
            row <= row + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/prng_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "prng_params.svh"

module prng_tb;
    import prng_pkg::*;

    localparam int   ITER     = `PRNG_ITER_CYCLES;
    localparam int   LANES    = `PRNG_LANES;
    // iterate lengths over all tests: idle 2, first 1, fixed 3+3, random 8, restart 2+4
    localparam int   RUN_ITERS = 23;
    localparam int   TIMEOUT  = 16 + RUN_ITERS * ITER + 100;
    localparam fix_t ONE      = fix_t'(1) <<< `PRNG_FRAC_BITS;
    localparam fix_t FRAC_MSK = (fix_t'(1) <<< `PRNG_FRAC_BITS) - 1;

    logic clk;
    logic reset_n;
    logic start;
    fix_t seed0, seed1, seed2;
    fix_t a00, a01, a02, a10, a11, a12, a20, a21, a22;
    fix_t sigma;
    logic valid;
    fix_t rand0, rand1, rand2;

    // reference model state, also the values driven on a start
    fix_t        x_m [LANES];
    fix_t        a_m [LANES][LANES];
    fix_t        sigma_m;
    logic [31:0] lfsr_state = 32'hcd3fb2bb;

    int errors;
    int checks;
    int tests_run;
    int cycle_count;

    prng_top uut (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (start),
        .seed0   (seed0),
        .seed1   (seed1),
        .seed2   (seed2),
        .a00     (a00),
        .a01     (a01),
        .a02     (a02),
        .a10     (a10),
        .a11     (a11),
        .a12     (a12),
        .a20     (a20),
        .a21     (a21),
        .a22     (a22),
        .sigma   (sigma),
        .valid   (valid),
        .rand0   (rand0),
        .rand1   (rand1),
        .rand2   (rand2)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hard stop if the DUT never finishes
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ======================================================================
    // stimulus source
    // ======================================================================

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // n bit two's complement, sign extended
    function automatic fix_t random_signed(input int n);
        fix_t v;
        v = fix_t'(random_bits(n) << (32 - n));
        return v >>> (32 - n);
    endfunction

    // ======================================================================
    // reference model
    // ======================================================================

    // q16.16 product, low word of the rescaled 64 bit result
    function automatic fix_t q_mul(input fix_t a, input fix_t b);
        longint pa;
        longint pb;
        longint p;
        pa = a;
        pb = b;
        p = pa * pb;
        return fix_t'(p >>> `PRNG_FRAC_BITS);
    endfunction

    function automatic fix_t sawtooth(input fix_t v);
        return v & FRAC_MSK;
    endfunction

    // x <= A x + frac(sigma x)
    task automatic model_advance;
        fix_t nx [LANES];
        for (int i = 0; i < LANES; i++) begin
            nx[i] = sawtooth(q_mul(sigma_m, x_m[i]));
            for (int j = 0; j < LANES; j++) begin
                nx[i] = nx[i] + q_mul(a_m[i][j], x_m[j]);
            end
        end
        x_m = nx;
    endtask

    // ======================================================================
    // drive and check helpers
    // ======================================================================

    task automatic check_value(input string name, input fix_t got, input fix_t exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    function automatic fix_t out_lane(input int i);
        case (i)
            0:       return rand0;
            1:       return rand1;
            default: return rand2;
        endcase
    endfunction

    task automatic check_outputs;
        for (int i = 0; i < LANES; i++) begin
            check_value($sformatf("rand%0d", i), out_lane(i), x_m[i]);
        end
    endtask

    // mask flips every bit, inputs are only sampled on start
    task automatic drive_inputs(input fix_t mask);
        seed0 <= x_m[0] ^ mask;
        seed1 <= x_m[1] ^ mask;
        seed2 <= x_m[2] ^ mask;
        a00   <= a_m[0][0] ^ mask;
        a01   <= a_m[0][1] ^ mask;
        a02   <= a_m[0][2] ^ mask;
        a10   <= a_m[1][0] ^ mask;
        a11   <= a_m[1][1] ^ mask;
        a12   <= a_m[1][2] ^ mask;
        a20   <= a_m[2][0] ^ mask;
        a21   <= a_m[2][1] ^ mask;
        a22   <= a_m[2][2] ^ mask;
        sigma <= sigma_m ^ mask;
    endtask

    // one cycle strobe, then seeds on the outputs with valid low
    task automatic start_run;
        @(posedge clk);
        start <= 1'b1;
        drive_inputs('0);
        @(posedge clk);
        start <= 1'b0;
        drive_inputs('1);
        @(negedge clk);
        check_value("valid", fix_t'(valid), 0);
        check_outputs();
    endtask

    // outputs hold until the pulse, which comes ITER cycles after the last one
    task automatic expect_iterate;
        int waited;
        waited = 1;
        @(negedge clk);
        while (!valid && waited < 2 * ITER) begin
            check_outputs();
            @(negedge clk);
            waited++;
        end
        if (!valid) begin
            $display("no valid pulse within %0d cycles at %0t", waited, $time);
            errors++;
        end else begin
            checks++;
            assert (waited == ITER) else begin
                $display("valid pulse came after %0d cycles instead of %0d", waited, ITER);
                errors++;
            end
            model_advance();
            check_outputs();
        end
    endtask

    task automatic randomize_values;
        for (int i = 0; i < LANES; i++) begin
            x_m[i] = random_bits(32);
            for (int j = 0; j < LANES; j++) begin
                // roughly -2.0 to 2.0
                a_m[i][j] = random_signed(18);
            end
        end
        // gain 0 to 16
        sigma_m = random_bits(20);
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        $display("test %-16s %s", name, (errors == errs_at_start) ? "pass" : "fail");
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    task automatic test_reset_idle;
        int e0;
        e0 = errors;
        repeat (2 * ITER) begin
            @(negedge clk);
            check_value("valid", fix_t'(valid), 0);
            check_value("rand0", rand0, 0);
            check_value("rand1", rand1, 0);
            check_value("rand2", rand2, 0);
        end
        end_test("reset_idle", e0);
    endtask

    task automatic test_first_pulse;
        int e0;
        e0 = errors;
        randomize_values();
        start_run();
        expect_iterate();
        end_test("first_pulse", e0);
    endtask

    // diagonal matrix and fixed gain, expected value straight from the old state
    task automatic test_fixed_case(input string name, input fix_t diag, input fix_t gain,
                                   input bit saw_only);
        int   e0;
        fix_t prev [LANES];
        e0 = errors;
        randomize_values();
        for (int i = 0; i < LANES; i++) begin
            for (int j = 0; j < LANES; j++) begin
                a_m[i][j] = (i == j) ? diag : '0;
            end
        end
        sigma_m = gain;
        start_run();
        repeat (3) begin
            prev = x_m;
            expect_iterate();
            for (int i = 0; i < LANES; i++) begin
                check_value($sformatf("rand%0d", i), out_lane(i),
                            saw_only ? {16'h0000, prev[i][15:0]} : prev[i]);
            end
        end
        end_test(name, e0);
    endtask

    task automatic test_random_run;
        int e0;
        e0 = errors;
        randomize_values();
        start_run();
        repeat (8) begin
            expect_iterate();
        end
        end_test("random_run", e0);
    endtask

    task automatic test_restart;
        int e0;
        e0 = errors;
        randomize_values();
        start_run();
        repeat (2) begin
            expect_iterate();
        end
        // part way into the third iteration
        repeat (5) begin
            @(negedge clk);
            check_value("valid", fix_t'(valid), 0);
        end
        randomize_values();
        start_run();
        repeat (4) begin
            expect_iterate();
        end
        end_test("restart", e0);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        cycle_count = 0;
        reset_n     = 1'b0;
        start       = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            x_m[i] = '0;
            for (int j = 0; j < LANES; j++) begin
                a_m[i][j] = '0;
            end
        end
        sigma_m = '0;
        drive_inputs('0);

        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_idle();
        test_first_pulse();
        test_fixed_case("identity_hold", ONE, '0, 1'b0);
        test_fixed_case("sawtooth_only", '0, ONE, 1'b1);
        test_random_run();
        test_restart();

        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/prng_pkg.sv
src/prng_control.sv
src/step_counter.sv
src/coeff_store.sv
src/state_store.sv
src/mac_unit.sv
src/prng_top.sv
tests/prng_tb.sv
